// File: logic/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// data path and pc width
`define XLEN 32

`define REG_ADDR_W 5

// entries in the queue between classifier and resolver
`define DECODE_FIFO_DEPTH 2

// no compressed instructions, so always a full word
`define PC_STEP 4

`endif

// File: logic/isa_pkg.sv
`include "decode_params.svh"

package isa_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0]            imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } i_fields_t;

  // S/B/U/J immediates are gathered from raw bits
  typedef union packed {
    r_fields_t         r;
    i_fields_t         i;
    logic [`XLEN-1:0]  raw;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_slt, alu_sltu, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [2:0] {
    class_alu, class_load, class_store, class_branch, class_jump, class_illegal
  } instr_class_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte = 2'b00,
    mem_half = 2'b01,
    mem_word = 2'b10
  } mem_size_e;

endpackage

// File: logic/pipe_pkg.sv
`include "decode_params.svh"

package pipe_pkg;

  typedef struct packed {
    isa_pkg::instr_u        instr;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
  } fetch_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    isa_pkg::instr_class_e  instr_class;
    isa_pkg::alu_op_e       alu_op;
    isa_pkg::mem_size_e     mem_size;
    logic                   mem_unsigned;
    // for jumps use_imm marks jalr (target is rs1 based)
    logic                   use_imm;
    logic                   use_pc;
    logic                   zero_a;
    logic [2:0]             branch_cond;
  } classified_t;

  typedef struct packed {
    isa_pkg::instr_class_e  instr_class;
    isa_pkg::alu_op_e       alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic [`XLEN-1:0]       store_data;
    logic [`XLEN-1:0]       mem_addr;
    isa_pkg::mem_size_e     mem_size;
    logic                   mem_unsigned;
    logic [`XLEN-1:0]       next_pc;
  } decoded_t;

endpackage

// File: logic/instr_classifier.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_classifier (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  in_valid,
  input  var pipe_pkg::fetch_t      in_data,
  output var logic                  in_ready,
  output var logic                  out_valid,
  input  var logic                  out_ready,
  output var pipe_pkg::classified_t out_data
);

  isa_pkg::instr_u       w;
  logic [`XLEN-1:0]      raw, i_imm, s_imm, b_imm, u_imm, j_imm, shamt;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  f7_base, f7_alt, is_shift;
  isa_pkg::alu_op_e      alu_op;
  pipe_pkg::classified_t c;

  assign w = in_data.instr;
  assign raw = w.raw;
  assign funct3 = w.r.funct3;
  assign funct7 = w.r.funct7;
  assign f7_base = funct7 == isa_pkg::funct7_base;
  assign f7_alt = funct7 == isa_pkg::funct7_alt;
  assign is_shift = funct3 == 3'b001 || funct3 == 3'b101;

  assign i_imm = {{20{raw[31]}}, w.i.imm};
  assign s_imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
  assign b_imm = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  assign u_imm = {raw[31:12], 12'b0};
  assign j_imm = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
  assign shamt = {{(`XLEN-`REG_ADDR_W){1'b0}}, w.r.rs2};

  // funct7 bit 5 picks sub (register form only) and sra
  always_comb begin
    case (funct3)
      3'b000: alu_op = (w.r.opcode == isa_pkg::opc_op && funct7[5]) ? isa_pkg::alu_sub
                                                                     : isa_pkg::alu_add;
      3'b001: alu_op = isa_pkg::alu_sll;
      3'b010: alu_op = isa_pkg::alu_slt;
      3'b011: alu_op = isa_pkg::alu_sltu;
      3'b100: alu_op = isa_pkg::alu_xor;
      3'b101: alu_op = funct7[5] ? isa_pkg::alu_sra : isa_pkg::alu_srl;
      3'b110: alu_op = isa_pkg::alu_or;
      default: alu_op = isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    c = '0;
    c.pc = in_data.pc;
    c.rs1_val = in_data.rs1_val;
    c.rs2_val = in_data.rs2_val;
    c.rd = w.r.rd;
    c.instr_class = isa_pkg::class_illegal;
    c.alu_op = isa_pkg::alu_add;
    c.mem_size = isa_pkg::mem_word;
    c.branch_cond = funct3;
    case (w.r.opcode)
      isa_pkg::opc_op: begin
        c.alu_op = alu_op;
        if (f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          c.instr_class = isa_pkg::class_alu;
        end
      end
      isa_pkg::opc_op_imm: begin
        c.alu_op = alu_op;
        c.use_imm = 1'b1;
        c.imm = is_shift ? shamt : i_imm;
        if (!is_shift || f7_base || (f7_alt && funct3 == 3'b101)) begin
          c.instr_class = isa_pkg::class_alu;
        end
      end
      isa_pkg::opc_load: begin
        c.use_imm = 1'b1;
        c.imm = i_imm;
        c.mem_size = isa_pkg::mem_size_e'(funct3[1:0]);
        c.mem_unsigned = funct3[2];
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          c.instr_class = isa_pkg::class_load;
        end
      end
      isa_pkg::opc_store: begin
        c.use_imm = 1'b1;
        c.imm = s_imm;
        c.mem_size = isa_pkg::mem_size_e'(funct3[1:0]);
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          c.instr_class = isa_pkg::class_store;
        end
      end
      isa_pkg::opc_branch: begin
        c.imm = b_imm;
        if (funct3[2:1] != 2'b01) begin
          c.instr_class = isa_pkg::class_branch;
        end
      end
      isa_pkg::opc_lui: begin
        c.instr_class = isa_pkg::class_alu;
        c.zero_a = 1'b1;
        c.use_imm = 1'b1;
        c.imm = u_imm;
      end
      isa_pkg::opc_auipc: begin
        c.instr_class = isa_pkg::class_alu;
        c.use_pc = 1'b1;
        c.use_imm = 1'b1;
        c.imm = u_imm;
      end
      isa_pkg::opc_jal: begin
        c.instr_class = isa_pkg::class_jump;
        c.use_pc = 1'b1;
        c.imm = j_imm;
      end
      isa_pkg::opc_jalr: begin
        c.use_pc = 1'b1;
        c.use_imm = 1'b1;
        c.imm = i_imm;
        if (funct3 == 3'b000) begin
          c.instr_class = isa_pkg::class_jump;
        end
      end
      default: begin
      end
    endcase
    // illegal words pass the register values through untouched
    if (c.instr_class == isa_pkg::class_illegal) begin
      c.imm = '0;
      c.use_imm = 1'b0;
      c.use_pc = 1'b0;
      c.mem_size = isa_pkg::mem_word;
      c.mem_unsigned = 1'b0;
    end
    if (c.instr_class inside {isa_pkg::class_store, isa_pkg::class_branch,
                              isa_pkg::class_illegal}) begin
      c.rd = '0;
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= c;
    end
  end

endmodule

// File: logic/decode_fifo.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_fifo (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  in_valid,
  input  var pipe_pkg::classified_t in_data,
  output var logic                  in_ready,
  output var logic                  out_valid,
  input  var logic                  out_ready,
  output var pipe_pkg::classified_t out_data
);

  localparam int depth = `DECODE_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  pipe_pkg::classified_t mem [depth];
  logic [ptr_w-1:0]      wr_ptr, rd_ptr;
  logic [cnt_w-1:0]      count;
  logic                  push, pop;

  assign in_ready = count != cnt_w'(depth);
  assign out_valid = count != '0;
  assign out_data = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// File: logic/operand_resolver.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module operand_resolver (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  in_valid,
  input  var pipe_pkg::classified_t in_data,
  output var logic                  in_ready,
  output var logic                  out_valid,
  input  var logic                  out_ready,
  output var pipe_pkg::decoded_t    out_data
);

  logic [`XLEN-1:0]   seq_pc, rel_target, reg_target;
  logic               taken;
  pipe_pkg::decoded_t d;

  assign seq_pc = in_data.pc + `XLEN'(`PC_STEP);
  assign rel_target = in_data.pc + in_data.imm;
  // jalr clears the low bit of its target
  assign reg_target = (in_data.rs1_val + in_data.imm) & ~`XLEN'(1);

  always_comb begin
    case (in_data.branch_cond)
      3'b000: taken = in_data.rs1_val == in_data.rs2_val;
      3'b001: taken = in_data.rs1_val != in_data.rs2_val;
      3'b100: taken = $signed(in_data.rs1_val) < $signed(in_data.rs2_val);
      3'b101: taken = $signed(in_data.rs1_val) >= $signed(in_data.rs2_val);
      3'b110: taken = in_data.rs1_val < in_data.rs2_val;
      3'b111: taken = in_data.rs1_val >= in_data.rs2_val;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    d.instr_class = in_data.instr_class;
    d.alu_op = in_data.alu_op;
    d.rd = in_data.rd;
    d.mem_size = in_data.mem_size;
    d.mem_unsigned = in_data.mem_unsigned;
    d.store_data = in_data.rs2_val;
    d.mem_addr = in_data.rs1_val + in_data.imm;

    if (in_data.use_pc) begin
      d.operand_a = in_data.pc;
    end else if (in_data.zero_a) begin
      d.operand_a = '0;
    end else begin
      d.operand_a = in_data.rs1_val;
    end

    // jumps write back the return address pc + 4
    if (in_data.instr_class == isa_pkg::class_jump) begin
      d.operand_b = `XLEN'(`PC_STEP);
    end else if (in_data.use_imm) begin
      d.operand_b = in_data.imm;
    end else begin
      d.operand_b = in_data.rs2_val;
    end

    case (in_data.instr_class)
      isa_pkg::class_branch: d.next_pc = taken ? rel_target : seq_pc;
      isa_pkg::class_jump: d.next_pc = in_data.use_imm ? reg_target : rel_target;
      default: d.next_pc = seq_pc;
    endcase
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= d;
    end
  end

endmodule

// File: logic/decode_top.sv
`timescale 1ns/1ps

module decode_top (
  input  var logic               clk,
  input  var logic               reset,
  input  var logic               in_valid,
  input  var pipe_pkg::fetch_t   in_data,
  output var logic               in_ready,
  output var logic               out_valid,
  input  var logic               out_ready,
  output var pipe_pkg::decoded_t out_data
);

  pipe_pkg::classified_t cls_data, fifo_data;
  logic                  cls_valid, cls_ready;
  logic                  fifo_valid, fifo_ready;

  instr_classifier u_classifier (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (cls_valid),
    .out_ready (cls_ready),
    .out_data  (cls_data)
  );

  // absorbs executor stalls so decode keeps going
  decode_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (cls_valid),
    .in_data   (cls_data),
    .in_ready  (cls_ready),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_data)
  );

  operand_resolver u_resolver (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (fifo_valid),
    .in_data   (fifo_data),
    .in_ready  (fifo_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// File: verif/decode_chk.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_chk (
  input var logic                                      clk,
  input var logic                                      reset,
  input var logic                                      in_valid,
  input var logic                                      out_valid,
  input var logic                                      out_ready,
  input var pipe_pkg::classified_t                     out_data,
  input var logic [$clog2(`DECODE_FIFO_DEPTH + 1)-1:0] count
);

  localparam int depth = `DECODE_FIFO_DEPTH;

  int failures = 0;

  // head must wait for the resolver
  head_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      failures++;
      $error("fifo head dropped or changed while out_ready was low");
    end

  // a push taken while full and stalled would raise the count
  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    count == depth && in_valid && !out_ready |=> count == depth)
    else begin
      failures++;
      $error("fifo accepted a push while full");
    end

  count_in_range: assert property (@(posedge clk) disable iff (reset)
    count <= depth)
    else begin
      failures++;
      $error("fifo occupancy above its depth");
    end

endmodule

bind decode_fifo decode_chk fifo_chk (.*);

// File: verif/decode_scoreboard.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_scoreboard #(
  parameter int num_entries = 1
) (
  input  var logic               clk,
  input  var logic               reset,
  input  var logic               out_valid,
  input  var logic               out_ready,
  input  var pipe_pkg::decoded_t out_data,
  input  var pipe_pkg::decoded_t expected [num_entries],
  output int                     received,
  output int                     errors
);

  task automatic check_field(input string name, input int idx,
                             input logic [`XLEN-1:0] want_val,
                             input logic [`XLEN-1:0] got_val);
    if (got_val !== want_val) begin
      errors++;
      $display("mismatch at %0t: entry %0d out_data.%s expected %h actual %h",
               $time, idx, name, want_val, got_val);
    end
  endtask

  task automatic compare_result(input int idx, input pipe_pkg::decoded_t got);
    pipe_pkg::decoded_t want;
    want = expected[idx];
    check_field("instr_class", idx, 32'(want.instr_class), 32'(got.instr_class));
    check_field("rd", idx, want.rd, got.rd);
    check_field("operand_a", idx, want.operand_a, got.operand_a);
    check_field("operand_b", idx, want.operand_b, got.operand_b);
    check_field("store_data", idx, want.store_data, got.store_data);
    check_field("next_pc", idx, want.next_pc, got.next_pc);
    if (want.instr_class == isa_pkg::class_alu) begin
      check_field("alu_op", idx, 32'(want.alu_op), 32'(got.alu_op));
    end
    // memory fields only mean something for loads and stores
    if (want.instr_class inside {isa_pkg::class_load, isa_pkg::class_store}) begin
      check_field("mem_addr", idx, want.mem_addr, got.mem_addr);
      check_field("mem_size", idx, 32'(want.mem_size), 32'(got.mem_size));
      check_field("mem_unsigned", idx, want.mem_unsigned, got.mem_unsigned);
    end
  endtask

  // sampled on the same edge that completes the transfer
  always @(posedge clk) begin
    if (reset) begin
      received = 0;
      errors = 0;
    end else if (out_valid && out_ready) begin
      if (received >= num_entries) begin
        errors++;
        $display("extra result at %0t after all %0d entries were delivered",
                 $time, num_entries);
      end else begin
        compare_result(received, out_data);
      end
      received++;
    end
  end

endmodule

// File: verif/decode_tb.sv
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_tb;

  localparam int num_entries = 44;
  localparam int wait_limit = 100;

  logic               clk = 1'b0;
  logic               reset;
  logic               in_valid;
  logic               in_ready;
  logic               out_valid;
  logic               out_ready;
  pipe_pkg::fetch_t   in_data;
  pipe_pkg::decoded_t out_data;

  pipe_pkg::fetch_t   stim [num_entries];
  pipe_pkg::decoded_t expected [num_entries];
  int                 n_entries = 0;
  logic [`XLEN-1:0]   pc = 32'h0000_1000;
  logic [31:0]        gap_state = 32'd5;
  logic [31:0]        stall_state = 32'd5;
  int                 received;
  int                 result_errors;
  int                 timeouts = 0;
  int                 waited;

  decode_top UUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  decode_scoreboard #(.num_entries(num_entries)) u_scoreboard (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .expected  (expected),
    .received  (received),
    .errors    (result_errors)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // executor stalls about one cycle in four
  always @(negedge clk) begin
    stall_state = lcg_next(stall_state);
    out_ready = stall_state[29:28] != 2'b00;
  end

  function automatic pipe_pkg::decoded_t base_result(input isa_pkg::instr_class_e cls,
                                                     input logic [`REG_ADDR_W-1:0] rd,
                                                     input logic [`XLEN-1:0] a,
                                                     input logic [`XLEN-1:0] b);
    pipe_pkg::decoded_t e;
    e = '0;
    e.instr_class = cls;
    e.rd = rd;
    e.operand_a = a;
    e.operand_b = b;
    e.next_pc = pc + `PC_STEP;
    return e;
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                           input logic [`XLEN-1:0] rs2_val, input pipe_pkg::decoded_t e);
    stim[n_entries].instr.raw = word;
    stim[n_entries].pc = pc;
    stim[n_entries].rs1_val = rs1_val;
    stim[n_entries].rs2_val = rs2_val;
    expected[n_entries] = e;
    expected[n_entries].store_data = rs2_val;
    n_entries++;
    pc = pc + `PC_STEP;
  endtask

  task automatic alu_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                           input logic [`XLEN-1:0] rs2_val, input isa_pkg::alu_op_e op,
                           input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] opnd_b);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_alu, rd, rs1_val, opnd_b);
    e.alu_op = op;
    add_entry(word, rs1_val, rs2_val, e);
  endtask

  // rs1_val must not leak into operand_a for lui and auipc
  task automatic upper_entry(input logic [31:0] word, input logic [`REG_ADDR_W-1:0] rd,
                             input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_alu, rd, a, b);
    e.alu_op = isa_pkg::alu_add;
    add_entry(word, 32'h0bad_0bad, 32'h0000_5eed, e);
  endtask

  task automatic jump_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                            input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] target);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_jump, rd, pc, `PC_STEP);
    e.next_pc = target;
    add_entry(word, rs1_val, 32'h0000_0077, e);
  endtask

  task automatic branch_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                              input logic [`XLEN-1:0] rs2_val, input logic taken,
                              input logic [`XLEN-1:0] offset);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_branch, 0, rs1_val, rs2_val);
    if (taken) begin
      e.next_pc = pc + offset;
    end
    add_entry(word, rs1_val, rs2_val, e);
  endtask

  task automatic load_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                            input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] imm,
                            input isa_pkg::mem_size_e size, input logic uns);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_load, rd, rs1_val, imm);
    e.mem_addr = rs1_val + imm;
    e.mem_size = size;
    e.mem_unsigned = uns;
    add_entry(word, rs1_val, 32'h0000_0077, e);
  endtask

  task automatic store_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                             input logic [`XLEN-1:0] rs2_val, input logic [`XLEN-1:0] imm,
                             input isa_pkg::mem_size_e size);
    pipe_pkg::decoded_t e;
    e = base_result(isa_pkg::class_store, 0, rs1_val, imm);
    e.mem_addr = rs1_val + imm;
    e.mem_size = size;
    add_entry(word, rs1_val, rs2_val, e);
  endtask

  task automatic illegal_entry(input logic [31:0] word, input logic [`XLEN-1:0] rs1_val,
                               input logic [`XLEN-1:0] rs2_val);
    add_entry(word, rs1_val, rs2_val,
              base_result(isa_pkg::class_illegal, 0, rs1_val, rs2_val));
  endtask

  task automatic build_table();
    alu_entry(32'h003100b3, 5, 7, isa_pkg::alu_add, 1, 7);
    alu_entry(32'h403100b3, 10, 3, isa_pkg::alu_sub, 1, 3);
    alu_entry(32'h003110b3, 1, 32'h1f, isa_pkg::alu_sll, 1, 32'h1f);
    alu_entry(32'h003120b3, -3, 2, isa_pkg::alu_slt, 1, 2);
    alu_entry(32'h003130b3, 3, -2, isa_pkg::alu_sltu, 1, -2);
    alu_entry(32'h003140b3, 32'hff00, 32'h0ff0, isa_pkg::alu_xor, 1, 32'h0ff0);
    alu_entry(32'h003150b3, 32'h8000_0000, 4, isa_pkg::alu_srl, 1, 4);
    alu_entry(32'h403150b3, 32'h8000_0000, 4, isa_pkg::alu_sra, 1, 4);
    alu_entry(32'h003160b3, 32'h0f0f, 32'hf0f0, isa_pkg::alu_or, 1, 32'hf0f0);
    alu_entry(32'h003170b3, 32'h0f0f, 32'hffff, isa_pkg::alu_and, 1, 32'hffff);
    // immediate forms where shifts carry the shamt
    alu_entry(32'hffb10213, 100, 32'h5555, isa_pkg::alu_add, 4, -5);
    alu_entry(32'h7ff14213, 1, 32'h5555, isa_pkg::alu_xor, 4, 32'h7ff);
    alu_entry(32'h00113213, 0, 32'h5555, isa_pkg::alu_sltu, 4, 1);
    alu_entry(32'h00711213, 3, 32'h5555, isa_pkg::alu_sll, 4, 7);
    alu_entry(32'h41f15213, -8, 32'h5555, isa_pkg::alu_sra, 4, 31);
    upper_entry(32'habcde2b7, 5, 0, 32'habcde000);
    upper_entry(32'h12345297, 5, pc, 32'h12345000);
    jump_entry(32'h010000ef, 32'h40, 1, pc + 16);
    jump_entry(32'hff9ff06f, 32'h40, 0, pc - 8);
    jump_entry(32'h004100e7, 32'h2001, 1, 32'h2004);
    jump_entry(32'hffd101e7, 32'h3000, 3, 32'h2ffc);
    // each branch taken and then not taken
    branch_entry(32'h00310463, 5, 5, 1, 8);
    branch_entry(32'h00310463, 5, 6, 0, 8);
    branch_entry(32'hfe3118e3, 1, 2, 1, -16);
    branch_entry(32'h00311463, 9, 9, 0, 8);
    branch_entry(32'h00314463, -1, 1, 1, 8);
    branch_entry(32'h00314463, 1, -1, 0, 8);
    branch_entry(32'h00315463, 3, 3, 1, 8);
    branch_entry(32'hfe3158e3, -1, 1, 0, -16);
    branch_entry(32'h00316463, 1, -1, 1, 8);
    branch_entry(32'h00316463, -1, 1, 0, 8);
    branch_entry(32'hfe3178e3, -1, 1, 1, -16);
    branch_entry(32'h00317463, 1, -1, 0, 8);
    load_entry(32'hffc10303, 32'h1000, 6, -4, isa_pkg::mem_byte, 0);
    load_entry(32'h00211303, 32'h1000, 6, 2, isa_pkg::mem_half, 0);
    load_entry(32'h7ff12303, 32'h1000, 6, 32'h7ff, isa_pkg::mem_word, 0);
    load_entry(32'h00114303, 32'h1000, 6, 1, isa_pkg::mem_byte, 1);
    load_entry(32'hffe15303, 32'h1000, 6, -2, isa_pkg::mem_half, 1);
    store_entry(32'h003102a3, 32'h2000, 32'hcafe, 5, isa_pkg::mem_byte);
    store_entry(32'hfe311d23, 32'h2000, 32'hbeef, -6, isa_pkg::mem_half);
    store_entry(32'h04312023, 32'h2000, 32'h1234_5678, 32'h40, isa_pkg::mem_word);
    // mul, csrrw and an all-zero word
    illegal_entry(32'h023100b3, 5, 7);
    illegal_entry(32'h300110f3, 5, 7);
    illegal_entry(32'h00000000, 5, 7);
  endtask

  task automatic send(input pipe_pkg::fetch_t item);
    int idle;
    int tries;
    idle = 0;
    tries = 0;
    gap_state = lcg_next(gap_state);
    while (gap_state[31:30] == 2'b00 && idle < 3) begin
      in_valid = 1'b0;
      @(negedge clk);
      idle++;
      gap_state = lcg_next(gap_state);
    end
    in_valid = 1'b1;
    in_data = item;
    while (!in_ready && tries < wait_limit) begin
      @(negedge clk);
      tries++;
    end
    if (!in_ready) begin
      $display("timeout at %0t: in_ready stayed low for %0d cycles", $time, wait_limit);
      timeouts++;
    end else begin
      @(negedge clk);
    end
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    build_table();
    if (n_entries != num_entries) begin
      $display("stimulus table holds %0d entries instead of %0d", n_entries, num_entries);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < num_entries && timeouts == 0; i++) begin
      send(stim[i]);
    end
    in_valid = 1'b0;

    waited = 0;
    while (received < num_entries && timeouts == 0 && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (received < num_entries && timeouts == 0) begin
      $display("timeout: only %0d of %0d results came out", received, num_entries);
      timeouts++;
    end
    // catch stray results after the last one
    repeat (4) @(negedge clk);

    $display("result errors: %0d, assertion failures: %0d, timeouts: %0d, results: %0d of %0d",
             result_errors, UUT.u_fifo.fifo_chk.failures, timeouts, received, num_entries);
    if (result_errors == 0 && UUT.u_fifo.fifo_chk.failures == 0 && timeouts == 0 &&
        received == num_entries && n_entries == num_entries) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_classifier.sv
logic/decode_fifo.sv
logic/operand_resolver.sv
logic/decode_top.sv
verif/decode_chk.sv
verif/decode_scoreboard.sv
verif/decode_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/pipe_pkg.sv
      - logic/instr_classifier.sv
      - logic/decode_fifo.sv
      - logic/operand_resolver.sv
      - logic/decode_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/decode_chk.sv
      - verif/decode_scoreboard.sv
      - verif/decode_tb.sv
